// File: compile.f
+incdir+.
flow_pkg.sv
new_flow_notif.sv
setup_fifo.sv
flow_setup_engine.sv
flow_state_query.sv
flow_table.sv
flow_notif_top.sv
tb_flow_notif_top.sv

// File: run_sim.sh
#!/bin/sh
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    -f compile.f --top-module tb_flow_notif_top -o tb_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/tb_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

exit 0

// File: tb_flow_notif_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "flow_config.svh"

module tb_flow_notif_top;

    import flow_pkg::*;

    localparam int NUM_FLOWS  = 1 << `FLOWID_W;
    localparam int BURST_LEN  = 3 * `SETUP_Q_DEPTH;
    localparam int RAND_OPS   = 40;
    localparam int TOTAL_OPS  = NUM_FLOWS + 2 + 3 * BURST_LEN + 3 + 2 + 2 * RAND_OPS + NUM_FLOWS;
    localparam int WATCHDOG_CYCLES = TOTAL_OPS * 50;

    logic                           clk;
    logic                           rst;
    logic                           noc_ctovr_notif_val;
    logic [`NOC_DATA_WIDTH-1:0]     noc_ctovr_notif_data;
    logic                           notif_noc_ctovr_rdy;
    logic                           query_val;
    logic [`FLOWID_W-1:0]           query_flowid;
    logic                           query_rdy;
    logic                           rsp_val;
    query_rsp                       rsp;
    logic                           rsp_rdy;

    integer                         seed;
    int                             stall_cycles;
    logic                           burst_done;

    // Reference model of the flow table, plus every value ever written per flow
    logic [NUM_FLOWS-1:0]           model_active;
    logic [`SEQ_W-1:0]              model_seq [NUM_FLOWS];
    logic [`FLOWID_W+`SEQ_W:0]      hist_q [$];

    flow_notif_top i_flow_notif_top (
         .clk                   (clk)
        ,.rst                   (rst)
        ,.noc_ctovr_notif_val   (noc_ctovr_notif_val)
        ,.noc_ctovr_notif_data  (noc_ctovr_notif_data)
        ,.notif_noc_ctovr_rdy   (notif_noc_ctovr_rdy)
        ,.query_val             (query_val)
        ,.query_flowid          (query_flowid)
        ,.query_rdy             (query_rdy)
        ,.rsp_val               (rsp_val)
        ,.rsp                   (rsp)
        ,.rsp_rdy               (rsp_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("Mismatch at time %0t: %s got 0x%0h expected 0x%0h",
                               $time, name, got, exp));
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_now($sformatf("Timeout: the tests did not finish within %0d cycles",
                           WATCHDOG_CYCLES));
    end

    function automatic logic matches_model(input logic [`FLOWID_W-1:0] fid, input flow_entry e);
        if (model_active[fid]) begin
            return e.active && (e.seq == model_seq[fid]);
        end
        return !e.active;
    endfunction

    // Every flow starts inactive, so an inactive reply is always a past state
    function automatic logic in_history(input logic [`FLOWID_W-1:0] fid, input flow_entry e);
        if (!e.active) begin
            return 1'b1;
        end
        foreach (hist_q[i]) begin
            if (hist_q[i] == {fid, e}) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic check_known(input logic [`FLOWID_W-1:0] fid, input flow_entry e);
        if (!in_history(fid, e)) begin
            check("rsp.entry", 64'(e), 64'({model_active[fid], model_seq[fid]}));
        end
    endtask

    // Tasks start and end 1 ns after a rising edge
    task automatic send_notif(input logic [`FLOWID_W-1:0] fid, input logic [`SEQ_W-1:0] seq);
        tcp_noc_hdr_flit flit;
        flit          = {$random(seed), $random(seed)};
        flit.flowid   = fid;
        flit.init_seq = seq;
        noc_ctovr_notif_val  = 1'b1;
        noc_ctovr_notif_data = flit;
        @(negedge clk);
        while (!notif_noc_ctovr_rdy) begin
            stall_cycles++;
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        noc_ctovr_notif_val = 1'b0;
        model_active[fid] = 1'b1;
        model_seq[fid]    = seq;
        hist_q.push_back({fid, 1'b1, seq});
    endtask

    task automatic query(input logic [`FLOWID_W-1:0] fid, input int hold, output query_rsp r);
        query_rsp first;
        query_val    = 1'b1;
        query_flowid = fid;
        if (hold > 0) begin
            rsp_rdy = 1'b0;
        end
        @(negedge clk);
        while (!query_rdy) @(negedge clk);
        @(posedge clk);
        #1;
        query_val = 1'b0;
        @(negedge clk);
        while (!rsp_val) @(negedge clk);
        first = rsp;
        if (hold > 0) begin
            repeat (hold) begin
                @(negedge clk);
                check("rsp_val", 64'(rsp_val), 64'(1));
                check("rsp", 64'(rsp), 64'(first));
            end
            @(posedge clk);
            #1;
            rsp_rdy = 1'b1;
            @(negedge clk);
            check("rsp_val", 64'(rsp_val), 64'(1));
            check("rsp", 64'(rsp), 64'(first));
        end
        @(posedge clk);
        #1;
        r = first;
        check("rsp.flowid", 64'(r.flowid), 64'(fid));
    endtask

    task automatic poll_flow(input logic [`FLOWID_W-1:0] fid);
        query_rsp   r;
        int         polls;
        logic       done;
        polls = 0;
        done  = 1'b0;
        while (!done) begin
            if (polls == 20) begin
                fail_now($sformatf("Flow %0d did not reach its expected state after 20 polls",
                                   fid));
            end
            query(fid, 0, r);
            polls++;
            check_known(fid, r.entry);
            done = matches_model(fid, r.entry);
        end
    endtask

    task automatic reset_state_test();
        query_rsp r;
        // Both engines come out of reset idle and ready
        @(negedge clk);
        check("notif_noc_ctovr_rdy", 64'(notif_noc_ctovr_rdy), 64'(1));
        check("query_rdy", 64'(query_rdy), 64'(1));
        check("rsp_val", 64'(rsp_val), 64'(0));
        @(posedge clk);
        #1;
        for (int i = 0; i < NUM_FLOWS; i++) begin
            query(`FLOWID_W'(i), 0, r);
            check("rsp.entry.active", 64'(r.entry.active), 64'(0));
        end
    endtask

    task automatic single_setup_test();
        send_notif(`FLOWID_W'(5), $random(seed));
        poll_flow(`FLOWID_W'(5));
    endtask

    // Flow 5 is settled, so its replies must be exact while the burst runs
    task automatic burst_test();
        query_rsp r;
        stall_cycles = 0;
        burst_done   = 1'b0;
        fork
            begin
                for (int i = 0; i < BURST_LEN; i++) begin
                    send_notif(`FLOWID_W'(10 + i), $random(seed));
                end
                burst_done = 1'b1;
            end
            begin
                while (!burst_done) begin
                    query(`FLOWID_W'(5), 0, r);
                    check("rsp.entry", 64'(r.entry), 64'({1'b1, model_seq[5]}));
                end
            end
        join
        if (stall_cycles < BURST_LEN - 1) begin
            fail_now("The notifier kept its ready high through the whole burst");
        end
        for (int i = 0; i < BURST_LEN; i++) begin
            poll_flow(`FLOWID_W'(10 + i));
        end
    endtask

    task automatic overwrite_test();
        logic [`SEQ_W-1:0] first_seq;
        first_seq = $random(seed);
        send_notif(`FLOWID_W'(30), first_seq);
        send_notif(`FLOWID_W'(30), first_seq ^ 32'h8000_0001);
        poll_flow(`FLOWID_W'(30));
    endtask

    task automatic backpressure_test();
        query_rsp r;
        query(`FLOWID_W'(5), 6, r);
        check("rsp.entry", 64'(r.entry), 64'({1'b1, model_seq[5]}));
        @(negedge clk);
        check("rsp_val", 64'(rsp_val), 64'(0));
        @(posedge clk);
        #1;
    endtask

    task automatic contention_test();
        logic [`FLOWID_W-1:0]   notif_fid [RAND_OPS];
        logic [`SEQ_W-1:0]      notif_seq [RAND_OPS];
        int                     notif_gap [RAND_OPS];
        logic [`FLOWID_W-1:0]   qry_fid [RAND_OPS];
        query_rsp               r;
        for (int i = 0; i < RAND_OPS; i++) begin
            notif_fid[i] = `FLOWID_W'($random(seed));
            notif_seq[i] = $random(seed);
            notif_gap[i] = $unsigned($random(seed)) % 4;
            qry_fid[i]   = `FLOWID_W'($random(seed));
        end
        fork
            begin
                for (int i = 0; i < RAND_OPS; i++) begin
                    send_notif(notif_fid[i], notif_seq[i]);
                    repeat (notif_gap[i]) begin
                        @(posedge clk);
                        #1;
                    end
                end
            end
            begin
                for (int i = 0; i < RAND_OPS; i++) begin
                    query(qry_fid[i], 0, r);
                    check_known(qry_fid[i], r.entry);
                end
            end
        join
        for (int i = 0; i < NUM_FLOWS; i++) begin
            poll_flow(`FLOWID_W'(i));
        end
    endtask

    initial begin
        seed                 = 32'heeeb_5cf9;
        rst                  = 1'b1;
        noc_ctovr_notif_val  = 1'b0;
        noc_ctovr_notif_data = '0;
        query_val            = 1'b0;
        query_flowid         = '0;
        rsp_rdy              = 1'b1;
        stall_cycles         = 0;
        burst_done           = 1'b0;
        model_active         = '0;
        for (int i = 0; i < NUM_FLOWS; i++) begin
            model_seq[i] = '0;
        end

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        reset_state_test();
        single_setup_test();
        burst_test();
        overwrite_test();
        backpressure_test();
        contention_test();

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: flow_notif_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "flow_config.svh"

module flow_notif_top (
     input  wire logic                          clk
    ,input  wire logic                          rst

    ,input  wire logic                          noc_ctovr_notif_val
    ,input  wire logic [`NOC_DATA_WIDTH-1:0]    noc_ctovr_notif_data
    ,output logic                               notif_noc_ctovr_rdy

    ,input  wire logic                          query_val
    ,input  wire logic [`FLOWID_W-1:0]          query_flowid
    ,output logic                               query_rdy

    ,output logic                               rsp_val
    ,output flow_pkg::query_rsp                 rsp
    ,input  wire logic                          rsp_rdy
);

    import flow_pkg::*;

    logic           notif_setup_q_wr_req;
    setup_q_entry   notif_setup_q_wr_data;
    logic           setup_q_wr_rdy;

    logic           setup_q_rd_val;
    setup_q_entry   setup_q_rd_data;
    logic           setup_q_rd_rdy;

    logic           setup_tbl_req_val;
    table_req       setup_tbl_req;
    logic           setup_tbl_req_rdy;

    logic           query_tbl_req_val;
    table_req       query_tbl_req;
    logic           query_tbl_req_rdy;
    logic           query_tbl_rsp_val;
    flow_entry      query_tbl_rsp_entry;

    new_flow_notif i_new_flow_notif (
         .clk                   (clk)
        ,.rst                   (rst)
        ,.noc_ctovr_notif_val   (noc_ctovr_notif_val)
        ,.noc_ctovr_notif_data  (noc_ctovr_notif_data)
        ,.notif_noc_ctovr_rdy   (notif_noc_ctovr_rdy)
        ,.notif_setup_q_wr_req  (notif_setup_q_wr_req)
        ,.notif_setup_q_wr_data (notif_setup_q_wr_data)
        ,.setup_q_wr_rdy        (setup_q_wr_rdy)
    );

    setup_fifo i_setup_fifo (
         .clk       (clk)
        ,.rst       (rst)
        ,.wr_val    (notif_setup_q_wr_req)
        ,.wr_data   (notif_setup_q_wr_data)
        ,.wr_rdy    (setup_q_wr_rdy)
        ,.rd_val    (setup_q_rd_val)
        ,.rd_data   (setup_q_rd_data)
        ,.rd_rdy    (setup_q_rd_rdy)
    );

    flow_setup_engine i_flow_setup_engine (
         .clk               (clk)
        ,.rst               (rst)
        ,.setup_q_rd_val    (setup_q_rd_val)
        ,.setup_q_rd_data   (setup_q_rd_data)
        ,.setup_q_rd_rdy    (setup_q_rd_rdy)
        ,.tbl_req_val       (setup_tbl_req_val)
        ,.tbl_req           (setup_tbl_req)
        ,.tbl_req_rdy       (setup_tbl_req_rdy)
    );

    flow_state_query i_flow_state_query (
         .clk           (clk)
        ,.rst           (rst)
        ,.query_val     (query_val)
        ,.query_flowid  (query_flowid)
        ,.query_rdy     (query_rdy)
        ,.tbl_req_val   (query_tbl_req_val)
        ,.tbl_req       (query_tbl_req)
        ,.tbl_req_rdy   (query_tbl_req_rdy)
        ,.tbl_rsp_val   (query_tbl_rsp_val)
        ,.tbl_rsp_entry (query_tbl_rsp_entry)
        ,.rsp_val       (rsp_val)
        ,.rsp           (rsp)
        ,.rsp_rdy       (rsp_rdy)
    );

    flow_table i_flow_table (
         .clk               (clk)
        ,.rst               (rst)
        ,.setup_req_val     (setup_tbl_req_val)
        ,.setup_req         (setup_tbl_req)
        ,.setup_req_rdy     (setup_tbl_req_rdy)
        ,.query_req_val     (query_tbl_req_val)
        ,.query_req         (query_tbl_req)
        ,.query_req_rdy     (query_tbl_req_rdy)
        ,.query_rsp_val     (query_tbl_rsp_val)
        ,.query_rsp_entry   (query_tbl_rsp_entry)
    );

endmodule

`default_nettype wire

// File: flow_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "flow_config.svh"

module flow_table (
     input  wire logic                  clk
    ,input  wire logic                  rst

    ,input  wire logic                  setup_req_val
    ,input  wire flow_pkg::table_req    setup_req
    ,output logic                       setup_req_rdy

    ,input  wire logic                  query_req_val
    ,input  wire flow_pkg::table_req    query_req
    ,output logic                       query_req_rdy

    ,output logic                       query_rsp_val
    ,output flow_pkg::flow_entry        query_rsp_entry
);

    import flow_pkg::*;

    localparam int NUM_FLOWS = 1 << `FLOWID_W;

    logic [`SEQ_W-1:0]      seq_mem [NUM_FLOWS];
    logic [NUM_FLOWS-1:0]   active_vec;

    // High when the query port won the last arbitration
    logic                   last_grant_query;

    logic                   grant_setup;
    logic                   grant_query;
    logic                   any_grant;
    table_req               sel_req;
    logic                   do_write;
    logic                   do_read;

    always_comb begin
        grant_setup = setup_req_val && (!query_req_val || last_grant_query);
        grant_query = query_req_val && !grant_setup;
    end

    assign setup_req_rdy = grant_setup;
    assign query_req_rdy = grant_query;
    assign any_grant     = grant_setup || grant_query;

    assign sel_req  = grant_setup ? setup_req : query_req;
    assign do_write = any_grant && (sel_req.op == TBL_WRITE);

    // Only the query port gets read data back
    assign do_read  = grant_query && (query_req.op == TBL_READ);

    always_ff @(posedge clk) begin
        if (rst) begin
            last_grant_query <= 1'b0;
            active_vec       <= '0;
            query_rsp_val    <= 1'b0;
        end else begin
            if (any_grant) begin
                last_grant_query <= grant_query;
            end
            if (do_write) begin
                active_vec[sel_req.flowid] <= sel_req.entry.active;
            end
            query_rsp_val <= do_read;
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            seq_mem[sel_req.flowid] <= sel_req.entry.seq;
        end
        if (do_read) begin
            query_rsp_entry.active <= active_vec[query_req.flowid];
            query_rsp_entry.seq    <= seq_mem[query_req.flowid];
        end
    end

endmodule

`default_nettype wire

// File: flow_state_query.sv
`timescale 1ns/1ps
`default_nettype none

`include "flow_config.svh"

module flow_state_query (
     input  wire logic                      clk
    ,input  wire logic                      rst

    ,input  wire logic                      query_val
    ,input  wire logic [`FLOWID_W-1:0]      query_flowid
    ,output logic                           query_rdy

    ,output logic                           tbl_req_val
    ,output flow_pkg::table_req             tbl_req
    ,input  wire logic                      tbl_req_rdy
    ,input  wire logic                      tbl_rsp_val
    ,input  wire flow_pkg::flow_entry       tbl_rsp_entry

    ,output logic                           rsp_val
    ,output flow_pkg::query_rsp             rsp
    ,input  wire logic                      rsp_rdy
);

    import flow_pkg::*;

    query_state_e           state_reg;
    query_state_e           state_next;

    logic [`FLOWID_W-1:0]   flowid_reg;
    flow_entry              entry_reg;
    logic                   store_flowid;
    logic                   store_entry;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= QRY_IDLE;
        end else begin
            state_reg <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (store_flowid) begin
            flowid_reg <= query_flowid;
        end
        if (store_entry) begin
            entry_reg <= tbl_rsp_entry;
        end
    end

    always_comb begin
        tbl_req.op     = TBL_READ;
        tbl_req.flowid = flowid_reg;
        tbl_req.entry  = '0;
    end

    assign rsp.flowid = flowid_reg;
    assign rsp.entry  = entry_reg;

    always_comb begin
        query_rdy    = 1'b0;
        tbl_req_val  = 1'b0;
        rsp_val      = 1'b0;
        store_flowid = 1'b0;
        store_entry  = 1'b0;
        state_next   = state_reg;

        case (state_reg)
            QRY_IDLE: begin
                query_rdy = 1'b1;
                if (query_val) begin
                    store_flowid = 1'b1;
                    state_next   = QRY_READ;
                end
            end
            QRY_READ: begin
                tbl_req_val = 1'b1;
                if (tbl_req_rdy) begin
                    state_next = QRY_WAIT;
                end
            end
            // The table answers exactly one cycle after granting the read
            QRY_WAIT: begin
                if (tbl_rsp_val) begin
                    store_entry = 1'b1;
                    state_next  = QRY_RESP;
                end
            end
            QRY_RESP: begin
                rsp_val = 1'b1;
                if (rsp_rdy) begin
                    state_next = QRY_IDLE;
                end
            end
        endcase
    end

endmodule

`default_nettype wire

// File: flow_setup_engine.sv
`timescale 1ns/1ps
`default_nettype none

module flow_setup_engine (
     input  wire logic                      clk
    ,input  wire logic                      rst

    ,input  wire logic                      setup_q_rd_val
    ,input  wire flow_pkg::setup_q_entry    setup_q_rd_data
    ,output logic                           setup_q_rd_rdy

    ,output logic                           tbl_req_val
    ,output flow_pkg::table_req             tbl_req
    ,input  wire logic                      tbl_req_rdy
);

    import flow_pkg::*;

    setup_state_e   state_reg;
    setup_state_e   state_next;

    setup_q_entry   pending_reg;
    logic           store_pending;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= SETUP_IDLE;
        end else begin
            state_reg <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (store_pending) begin
            pending_reg <= setup_q_rd_data;
        end
    end

    // A new flow starts active at its initial sequence number.
    // A later notice for the same flow simply overwrites the entry.
    always_comb begin
        tbl_req.op           = TBL_WRITE;
        tbl_req.flowid       = pending_reg.flowid;
        tbl_req.entry.active = 1'b1;
        tbl_req.entry.seq    = pending_reg.init_seq;
    end

    always_comb begin
        setup_q_rd_rdy = 1'b0;
        tbl_req_val    = 1'b0;
        store_pending  = 1'b0;
        state_next     = state_reg;

        case (state_reg)
            SETUP_IDLE: begin
                setup_q_rd_rdy = 1'b1;
                if (setup_q_rd_val) begin
                    store_pending = 1'b1;
                    state_next    = SETUP_WRITE;
                end
            end
            SETUP_WRITE: begin
                tbl_req_val = 1'b1;
                if (tbl_req_rdy) begin
                    state_next = SETUP_IDLE;
                end
            end
        endcase
    end

endmodule

`default_nettype wire

// File: setup_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "flow_config.svh"

module setup_fifo (
     input  wire logic                      clk
    ,input  wire logic                      rst

    ,input  wire logic                      wr_val
    ,input  wire flow_pkg::setup_q_entry    wr_data
    ,output logic                           wr_rdy

    ,output logic                           rd_val
    ,output flow_pkg::setup_q_entry         rd_data
    ,input  wire logic                      rd_rdy
);

    import flow_pkg::*;

    localparam int PTR_W = $clog2(`SETUP_Q_DEPTH);
    localparam int CNT_W = $clog2(`SETUP_Q_DEPTH + 1);

    setup_q_entry       mem [`SETUP_Q_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;

    logic               wr_fire;
    logic               rd_fire;

    assign wr_rdy  = (count != CNT_W'(`SETUP_Q_DEPTH));
    assign rd_val  = (count != '0);
    assign rd_data = mem[rd_ptr];

    assign wr_fire = wr_val && wr_rdy;
    assign rd_fire = rd_val && rd_rdy;

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= (wr_ptr == PTR_W'(`SETUP_Q_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= (rd_ptr == PTR_W'(`SETUP_Q_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // A read and a write in the same cycle leave the count as it is
            case ({wr_fire, rd_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: new_flow_notif.sv
`timescale 1ns/1ps
`default_nettype none

`include "flow_config.svh"

module new_flow_notif (
     input  wire logic                          clk
    ,input  wire logic                          rst

    ,input  wire logic                          noc_ctovr_notif_val
    ,input  wire logic [`NOC_DATA_WIDTH-1:0]    noc_ctovr_notif_data
    ,output logic                               notif_noc_ctovr_rdy

    ,output logic                               notif_setup_q_wr_req
    ,output flow_pkg::setup_q_entry             notif_setup_q_wr_data
    ,input  wire logic                          setup_q_wr_rdy
);

    import flow_pkg::*;

    notif_state_e       state_reg;
    notif_state_e       state_next;

    tcp_noc_hdr_flit    hdr_flit_cast;
    setup_q_entry       entry_reg;
    logic               store_entry;

    assign hdr_flit_cast = noc_ctovr_notif_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= READY;
        end else begin
            state_reg <= state_next;
        end
    end

    // Fields are captured on the accepting edge and held while the queue is full
    always_ff @(posedge clk) begin
        if (store_entry) begin
            entry_reg.flowid   <= hdr_flit_cast.flowid;
            entry_reg.init_seq <= hdr_flit_cast.init_seq;
        end
    end

    assign notif_setup_q_wr_data = entry_reg;

    always_comb begin
        notif_noc_ctovr_rdy  = 1'b0;
        notif_setup_q_wr_req = 1'b0;
        store_entry          = 1'b0;
        state_next           = state_reg;

        case (state_reg)
            READY: begin
                notif_noc_ctovr_rdy = 1'b1;
                if (noc_ctovr_notif_val) begin
                    store_entry = 1'b1;
                    state_next  = WRITE_FIFO;
                end
            end
            WRITE_FIFO: begin
                notif_setup_q_wr_req = 1'b1;
                if (setup_q_wr_rdy) begin
                    state_next = READY;
                end
            end
        endcase
    end

endmodule

`default_nettype wire

// File: flow_pkg.sv
`default_nettype none

`include "flow_config.svh"

package flow_pkg;

    // New-flow notice as it arrives on the NoC, reserved bits on top
    typedef struct packed {
        logic [`NOC_DATA_WIDTH-`FLOWID_W-`SEQ_W-1:0]  reserved;
        logic [`FLOWID_W-1:0]                       flowid;
        logic [`SEQ_W-1:0]                          init_seq;
    } tcp_noc_hdr_flit;

    typedef struct packed {
        logic [`FLOWID_W-1:0]   flowid;
        logic [`SEQ_W-1:0]      init_seq;
    } setup_q_entry;

    typedef struct packed {
        logic                   active;
        logic [`SEQ_W-1:0]      seq;
    } flow_entry;

    typedef enum logic {
        TBL_READ    = 1'b0,
        TBL_WRITE   = 1'b1
    } table_op_e;

    typedef struct packed {
        table_op_e              op;
        logic [`FLOWID_W-1:0]   flowid;
        flow_entry              entry;
    } table_req;

    typedef struct packed {
        logic [`FLOWID_W-1:0]   flowid;
        flow_entry              entry;
    } query_rsp;

    typedef enum logic {
        READY       = 1'b0,
        WRITE_FIFO  = 1'b1
    } notif_state_e;

    typedef enum logic {
        SETUP_IDLE  = 1'b0,
        SETUP_WRITE = 1'b1
    } setup_state_e;

    typedef enum logic [1:0] {
        QRY_IDLE    = 2'd0,
        QRY_READ    = 2'd1,
        QRY_WAIT    = 2'd2,
        QRY_RESP    = 2'd3
    } query_state_e;

endpackage

`default_nettype wire

// File: flow_config.svh
`ifndef FLOW_CONFIG_SVH
`define FLOW_CONFIG_SVH

// Width of one flit on the NoC
`define NOC_DATA_WIDTH 64

// Flow id width, which sets the table to 64 flows
`define FLOWID_W 6

// TCP sequence number width
`define SEQ_W 32

// Pending setups held between the notifier and the setup engine
`define SETUP_Q_DEPTH 4

`endif
